//--- logic/fetch_pkg.sv
// fetch front end shared definitions
// word and halfword widths, FIFO space width
// state encodings of the word fetcher and the instruction aligner

package fetch_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  // instruction and memory word width
  localparam int unsigned INSTR_W = 32;
  // compressed instruction width
  localparam int unsigned HALF_W  = 16;
  // width of the free entry count reported by the FIFO
  localparam int unsigned SPACE_W = 3;

  //////////////////////////////////////////////////
  // state encodings
  //////////////////////////////////////////////////
  // four-phase memory master
  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_RELEASE
  } fetch_state_e;

  // halfword realignment
  typedef enum logic [2:0] {
    ALIGNED32,
    ALIGNED16,
    MISALIGNED32,
    MISALIGNED16,
    BRANCH_MISALIGNED,
    WAIT_VALID_MISALIGNED16
  } align_state_e;

endpackage

//--- logic/word_fetcher.sv
`timescale 1ns/1ps
// word fetcher
// four-phase req/ack master that reads sequential 32-bit words from
// instruction memory and pushes them into the prefetch FIFO
// a branch moves the next fetch address and marks an open response stale

module word_fetcher #(
  parameter logic [fetch_pkg::INSTR_W-1:0] BOOT_ADDR = '0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          branch_i,
  input  logic [fetch_pkg::INSTR_W-1:0] branch_addr_i,
  input  logic [fetch_pkg::SPACE_W-1:0] fifo_space_i,
  input  logic                          mem_ack_i,
  input  logic [fetch_pkg::INSTR_W-1:0] mem_rdata_i,
  output logic                          mem_req_o,
  output logic [fetch_pkg::INSTR_W-1:0] mem_addr_o,
  output logic                          push_o,
  output logic [fetch_pkg::INSTR_W-1:0] push_data_o
);

  // word address of the first fetch after reset
  localparam logic [fetch_pkg::INSTR_W-1:0] BOOT_WORD =
    {BOOT_ADDR[fetch_pkg::INSTR_W-1:2], 2'b00};
  localparam logic [fetch_pkg::INSTR_W-1:0] WORD_BYTES = fetch_pkg::INSTR_W'(4);

  fetch_pkg::fetch_state_e       state_q, state_d;
  logic [fetch_pkg::INSTR_W-1:0] next_addr_q;
  logic [fetch_pkg::INSTR_W-1:0] req_addr_q;
  logic                          stale_q;
  logic                          resp_taken;
  logic                          can_start;
  logic                          launch;

  //////////////////////////////////////////////////
  // handshake control
  //////////////////////////////////////////////////
  // ack sampled high while req is up closes the data phase
  assign resp_taken = (state_q == fetch_pkg::F_REQ) && mem_ack_i;

  // no words are in flight outside F_REQ, so any free entry is room
  // a branch cycle waits one clock for the flushed FIFO
  assign can_start  = !mem_ack_i && (fifo_space_i != '0) && !branch_i;
  assign launch     = can_start &&
                      ((state_q == fetch_pkg::F_IDLE) || (state_q == fetch_pkg::F_RELEASE));

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::F_IDLE: begin
        if (launch) begin
          state_d = fetch_pkg::F_REQ;
        end
      end
      fetch_pkg::F_REQ: begin
        // drop req right after the sampling edge
        if (mem_ack_i) begin
          state_d = fetch_pkg::F_RELEASE;
        end
      end
      fetch_pkg::F_RELEASE: begin
        // memory must lower ack before the next request
        if (!mem_ack_i) begin
          state_d = launch ? fetch_pkg::F_REQ : fetch_pkg::F_IDLE;
        end
      end
      default: state_d = fetch_pkg::F_IDLE;
    endcase
  end

  assign mem_req_o   = (state_q == fetch_pkg::F_REQ);
  // address register only loads at launch, so it is steady under req
  assign mem_addr_o  = req_addr_q;

  // stale data finishes its handshake but never reaches the FIFO
  assign push_o      = resp_taken && !stale_q;
  assign push_data_o = mem_rdata_i;

  //////////////////////////////////////////////////
  // state and address registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= fetch_pkg::F_IDLE;
      next_addr_q <= BOOT_WORD;
      req_addr_q  <= BOOT_WORD;
      stale_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        req_addr_q <= next_addr_q;
      end
      // branch target wins over the sequential step
      if (branch_i) begin
        next_addr_q <= {branch_addr_i[fetch_pkg::INSTR_W-1:2], 2'b00};
      end else if (push_o) begin
        next_addr_q <= next_addr_q + WORD_BYTES;
      end
      // one stale response at most, cleared when it completes
      if (resp_taken) begin
        stale_q <= 1'b0;
      end else if (branch_i && (state_q == fetch_pkg::F_REQ)) begin
        stale_q <= 1'b1;
      end
    end
  end

endmodule

//--- logic/prefetch_fifo.sv
`timescale 1ns/1ps
// prefetch FIFO
// circular word buffer between the word fetcher and the aligner
// flush empties it in one cycle and reports free entries to the fetcher

module prefetch_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          push_i,
  input  logic [fetch_pkg::INSTR_W-1:0] push_data_i,
  input  logic                          pop_i,
  output logic                          valid_o,
  output logic [fetch_pkg::INSTR_W-1:0] data_o,
  output logic [fetch_pkg::SPACE_W-1:0] space_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  logic [fetch_pkg::INSTR_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]              wr_ptr_q;
  logic [PTR_W-1:0]              rd_ptr_q;
  logic [PTR_W-1:0]              wr_ptr_nxt;
  logic [PTR_W-1:0]              rd_ptr_nxt;
  logic [CNT_W-1:0]              count_q;
  logic                          push_ok;
  logic                          pop_ok;

  // flush drops a push or pop in the same cycle
  assign push_ok    = push_i && (count_q != FULL_CNT) && !flush_i;
  assign pop_ok     = pop_i && (count_q != '0) && !flush_i;

  // wrap explicitly for depths that are not a power of two
  assign wr_ptr_nxt = (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_nxt = (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;

  assign valid_o    = (count_q != '0);
  assign data_o     = mem_q[rd_ptr_q];
  assign space_o    = fetch_pkg::SPACE_W'(FULL_CNT - count_q);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_nxt;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_nxt;
      end
      // simultaneous push and pop keep the count
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- logic/instr_aligner.sv
`timescale 1ns/1ps
// instruction aligner
// turns the word stream from the prefetch FIFO into RV32C instructions
// joins 32-bit instructions that straddle a word boundary, puts compressed
// ones out zero-extended and flagged, and tracks the pc of each instruction
// a branch reloads the pc at any halfword address

module instr_aligner #(
  parameter logic [fetch_pkg::INSTR_W-1:0] BOOT_ADDR = '0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_valid_i,
  input  logic [fetch_pkg::INSTR_W-1:0] mem_content_i,
  input  logic                          id_ready_i,
  input  logic                          branch_i,
  input  logic [fetch_pkg::INSTR_W-1:0] branch_addr_i,
  output logic                          pop_o,
  output logic [fetch_pkg::INSTR_W-1:0] instr_o,
  output logic                          instr_valid_o,
  output logic                          instr_compressed_o,
  output logic [fetch_pkg::INSTR_W-1:0] pc_o
);

  // boot at an odd halfword behaves like a branch there
  localparam fetch_pkg::align_state_e RESET_STATE =
    BOOT_ADDR[1] ? fetch_pkg::BRANCH_MISALIGNED : fetch_pkg::ALIGNED32;
  localparam logic [fetch_pkg::HALF_W-1:0] ZERO_HALF = '0;

  fetch_pkg::align_state_e       state_q, state_d;
  logic [fetch_pkg::INSTR_W-1:0] pc_q, pc_d;
  logic [fetch_pkg::INSTR_W-1:0] pc_plus2;
  logic [fetch_pkg::INSTR_W-1:0] pc_plus4;
  logic [fetch_pkg::HALF_W-1:0]  r_instr_q;
  logic [fetch_pkg::HALF_W-1:0]  lo_half;
  logic [fetch_pkg::HALF_W-1:0]  hi_half;
  logic                          update_state;
  logic                          raw_instr_hold;

  assign lo_half  = mem_content_i[fetch_pkg::HALF_W-1:0];
  assign hi_half  = mem_content_i[fetch_pkg::INSTR_W-1:fetch_pkg::HALF_W];

  assign pc_plus2 = pc_q + fetch_pkg::INSTR_W'(2);
  assign pc_plus4 = pc_q + fetch_pkg::INSTR_W'(4);
  assign pc_o     = pc_q;

  // head word leaves the FIFO once its last useful half is taken
  // a held word stays at the head for the next instruction
  assign pop_o    = update_state && fetch_valid_i && !raw_instr_hold && !branch_i;

  //////////////////////////////////////////////////
  // realignment FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_d            = state_q;
    pc_d               = pc_q;
    instr_o            = mem_content_i;
    instr_valid_o      = fetch_valid_i;
    instr_compressed_o = 1'b0;
    raw_instr_hold     = 1'b0;
    update_state       = 1'b0;

    case (state_q)
      // pc sits on the lower half of the head word
      fetch_pkg::ALIGNED32,
      fetch_pkg::MISALIGNED16,
      fetch_pkg::WAIT_VALID_MISALIGNED16: begin
        if (lo_half[1:0] == 2'b11) begin
          // whole word is one instruction
          state_d = fetch_pkg::ALIGNED32;
          pc_d    = pc_plus4;
          instr_o = mem_content_i;
        end else begin
          // compressed in the lower half, upper half kept for later
          state_d            = fetch_pkg::ALIGNED16;
          pc_d               = pc_plus2;
          instr_o            = {ZERO_HALF, lo_half};
          instr_compressed_o = 1'b1;
        end
        update_state = fetch_valid_i && id_ready_i;
      end

      // pc sits on the stored upper half of the word already popped
      fetch_pkg::ALIGNED16,
      fetch_pkg::MISALIGNED32: begin
        if (r_instr_q[1:0] == 2'b11) begin
          // 32-bit instruction continues in the head word
          state_d      = fetch_pkg::MISALIGNED32;
          pc_d         = pc_plus4;
          instr_o      = {lo_half, r_instr_q};
          update_state = fetch_valid_i && id_ready_i;
        end else begin
          // compressed and complete in the stored half
          // no need to wait on the FIFO
          instr_o            = {ZERO_HALF, r_instr_q};
          instr_valid_o      = 1'b1;
          instr_compressed_o = 1'b1;
          pc_d               = pc_plus2;
          state_d            = fetch_valid_i ? fetch_pkg::MISALIGNED16
                                             : fetch_pkg::WAIT_VALID_MISALIGNED16;
          // keep the head word, it starts the next instruction
          raw_instr_hold     = fetch_valid_i;
          update_state       = id_ready_i;
        end
      end

      // branch landed on the upper half of the head word
      fetch_pkg::BRANCH_MISALIGNED: begin
        if (hi_half[1:0] == 2'b11) begin
          // first half of a split instruction
          // pop and store it with nothing presented
          state_d       = fetch_pkg::MISALIGNED32;
          instr_valid_o = 1'b0;
          update_state  = fetch_valid_i;
        end else begin
          state_d            = fetch_pkg::ALIGNED32;
          pc_d               = pc_plus2;
          instr_o            = {ZERO_HALF, hi_half};
          instr_compressed_o = 1'b1;
          update_state       = fetch_valid_i && id_ready_i;
        end
      end

      default: begin
        state_d = fetch_pkg::ALIGNED32;
      end
    endcase

    // redirect overrides whatever the current state wanted
    if (branch_i) begin
      pc_d         = branch_addr_i;
      state_d      = branch_addr_i[1] ? fetch_pkg::BRANCH_MISALIGNED : fetch_pkg::ALIGNED32;
      update_state = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET_STATE;
      pc_q    <= BOOT_ADDR;
    end else if (update_state) begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // upper half of every word that leaves the FIFO
  always_ff @(posedge clk) begin
    if (pop_o) begin
      r_instr_q <= hi_half;
    end
  end

endmodule

//--- logic/fetch_stage_top.sv
`timescale 1ns/1ps
// instruction fetch stage
// word fetcher, prefetch FIFO and instruction aligner in a chain
// the branch pulse redirects all three and flushes the FIFO

module fetch_stage_top #(
  parameter int unsigned                   FIFO_DEPTH = 4,
  parameter logic [fetch_pkg::INSTR_W-1:0] BOOT_ADDR  = '0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          branch_i,
  input  logic [fetch_pkg::INSTR_W-1:0] branch_addr_i,
  input  logic                          id_ready_i,
  input  logic                          mem_ack_i,
  input  logic [fetch_pkg::INSTR_W-1:0] mem_rdata_i,
  output logic                          mem_req_o,
  output logic [fetch_pkg::INSTR_W-1:0] mem_addr_o,
  output logic [fetch_pkg::INSTR_W-1:0] instr_o,
  output logic                          instr_valid_o,
  output logic                          instr_compressed_o,
  output logic [fetch_pkg::INSTR_W-1:0] pc_o
);

  // fetcher to FIFO
  logic                          push;
  logic [fetch_pkg::INSTR_W-1:0] push_data;
  logic [fetch_pkg::SPACE_W-1:0] fifo_space;
  // FIFO to aligner
  logic                          fifo_valid;
  logic [fetch_pkg::INSTR_W-1:0] fifo_data;
  logic                          pop;

  word_fetcher #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_word_fetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fifo_space_i  (fifo_space),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .push_o        (push),
    .push_data_o   (push_data)
  );

  // flush is the branch pulse itself
  prefetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .valid_o     (fifo_valid),
    .data_o      (fifo_data),
    .space_o     (fifo_space)
  );

  instr_aligner #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_instr_aligner (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_valid_i      (fifo_valid),
    .mem_content_i      (fifo_data),
    .id_ready_i         (id_ready_i),
    .branch_i           (branch_i),
    .branch_addr_i      (branch_addr_i),
    .pop_o              (pop),
    .instr_o            (instr_o),
    .instr_valid_o      (instr_valid_o),
    .instr_compressed_o (instr_compressed_o),
    .pc_o               (pc_o)
  );

endmodule

//--- dv/tb_fetch_stage.sv
`timescale 1ns/1ps
// fetch stage testbench
// random RV32C program image behind a four-phase memory responder,
// expected pc/instruction queue built from the image, random id_ready,
// branches to word and halfword targets, protocol checks on the memory port

module tb_fetch_stage;

  localparam int unsigned             FIFO_DEPTH     = 4;
  localparam logic [31:0]             BOOT_ADDR      = 32'h0;
  localparam int                      CLK_PERIOD     = 10;
  localparam logic [31:0]             SEED           = 32'd82215;
  localparam int                      HW_BITS        = 12;
  localparam int                      HW             = 1 << HW_BITS;
  localparam int                      N_RESET        = 150;
  localparam int                      N_BACKPRESSURE = 200;
  localparam int                      N_BRANCH       = 80;
  localparam int                      N_STALL        = 60;
  localparam int                      BRANCH_WAIT    = 20;
  localparam int                      N_TOTAL        = N_RESET + N_BACKPRESSURE + 3 * N_BRANCH;
  localparam int                      WATCHDOG_CYCLES =
    N_TOTAL * 40 + N_STALL + 3 * BRANCH_WAIT + 500;

  logic        clk           = 1'b0;
  logic        rst_n         = 1'b0;
  logic        branch_i      = 1'b0;
  logic [31:0] branch_addr_i = 32'h0;
  logic        id_ready_i    = 1'b0;
  logic        mem_ack_i     = 1'b0;
  logic [31:0] mem_rdata_i   = 32'h0;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic [31:0] instr_o;
  logic        instr_valid_o;
  logic        instr_compressed_o;
  logic [31:0] pc_o;

  // program image in halfwords with a mark on each instruction start
  logic [15:0] prog [HW];
  bit          is_start [HW];
  // expected {pc, instruction} in program order
  logic [63:0] exp_q [$];
  logic [31:0] stream_pc;
  logic [31:0] prog_rng = SEED;
  logic [31:0] rdy_rng  = SEED ^ 32'h0000_5a5a;
  logic [31:0] mem_rng  = SEED ^ 32'h0000_a5a5;
  logic [1:0]  ack_wait = 2'd0;
  int          ready_pct = 100;
  string       cur_test  = "reset_stream";
  int          errors = 0;
  int          test_errors_base = 0;
  int          test_checked = 0;
  int          total_checked = 0;
  int          tests_run = 0;

  fetch_stage_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .BOOT_ADDR  (BOOT_ADDR)
  ) i_fetch_stage_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .branch_addr_i      (branch_addr_i),
    .id_ready_i         (id_ready_i),
    .mem_ack_i          (mem_ack_i),
    .mem_rdata_i        (mem_rdata_i),
    .mem_req_o          (mem_req_o),
    .mem_addr_o         (mem_addr_o),
    .instr_o            (instr_o),
    .instr_valid_o      (instr_valid_o),
    .instr_compressed_o (instr_compressed_o),
    .pc_o               (pc_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // image wraps, so every address maps somewhere
  function automatic int hw_index(input logic [31:0] addr);
    return int'(addr[HW_BITS:1]);
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return {prog[hw_index(addr + 32'd2)], prog[hw_index(addr)]};
  endfunction

  // low bits 11 mean a 32-bit instruction in RV32C
  function automatic logic [31:0] expected_instr(input logic [31:0] pc);
    logic [15:0] lo;
    lo = prog[hw_index(pc)];
    if (lo[1:0] == 2'b11) begin
      return {prog[hw_index(pc + 32'd2)], lo};
    end
    return {16'h0000, lo};
  endfunction

  function automatic int find_target(input int from, input bit odd, input bit want32);
    for (int i = from; i < HW; i++) begin
      if (is_start[i] && (i[0] == odd) && ((prog[i][1:0] == 2'b11) == want32)) begin
        return i;
      end
    end
    errors++;
    $display("no branch target found from halfword %0d", from);
    return from;
  endfunction

  // random mix with about half 32-bit
  task automatic build_program();
    int idx;
    idx = 0;
    while (idx < HW) begin
      prog_rng = xorshift32(prog_rng);
      is_start[idx] = 1'b1;
      if (prog_rng[31] && (idx + 1 < HW)) begin
        prog[idx]     = {prog_rng[15:2], 2'b11};
        prog[idx + 1] = prog_rng[29:14];
        idx += 2;
      end else begin
        prog[idx] = {prog_rng[15:2], 2'(prog_rng[17:16] % 3)};
        idx += 1;
      end
    end
  endtask

  task automatic queue_stream(input logic [31:0] start, input int count);
    logic [31:0] pc;
    logic [31:0] instr;
    pc = start;
    for (int i = 0; i < count; i++) begin
      instr = expected_instr(pc);
      exp_q.push_back({pc, instr});
      pc = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    end
    stream_pc        = pc;
    test_checked     = 0;
    test_errors_base = errors;
  endtask

  // returns at a falling edge once every expected entry was accepted
  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (exp_q.size() != 0);
  endtask

  task automatic report_test();
    tests_run++;
    total_checked += test_checked;
    $display("test %s: %0d instructions checked, %0d errors",
             cur_test, test_checked, errors - test_errors_base);
  endtask

  task automatic check_accept(input logic [31:0] exp_pc, input logic [31:0] exp_instr);
    logic exp_c;
    exp_c = (exp_instr[1:0] != 2'b11);
    test_checked++;
    assert (pc_o == exp_pc) else begin
      errors++;
      $display("MISMATCH %s pc expected %h actual %h", cur_test, exp_pc, pc_o);
    end
    assert (instr_o == exp_instr) else begin
      errors++;
      $display("MISMATCH %s instr expected %h actual %h", cur_test, exp_instr, instr_o);
    end
    assert (instr_compressed_o == exp_c) else begin
      errors++;
      $display("MISMATCH %s compressed expected %b actual %b", cur_test, exp_c,
               instr_compressed_o);
    end
  endtask

  // called at a falling edge with the queue empty
  // the pulse lands inside an open request when one comes soon enough
  // so the response in flight has to be dropped
  task automatic take_branch(input string name, input logic [31:0] target, input int count);
    int waited;
    cur_test = name;
    waited   = 0;
    @(posedge clk);
    while (!(mem_req_o && !mem_ack_i && (ack_wait != 2'd0)) && (waited < BRANCH_WAIT)) begin
      @(posedge clk);
      waited++;
    end
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    @(negedge clk);
    queue_stream(target, count);
    @(posedge clk);
    branch_i      <= 1'b0;
    wait_drain();
    report_test();
  endtask

  //////////////////////////////////////////////////
  // memory responder and consumer
  //////////////////////////////////////////////////
  // four-phase slave that acks after 0 to 3 idle cycles and drops ack once req is low
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack_i <= 1'b0;
      ack_wait  <= 2'd0;
    end else if (mem_ack_i) begin
      if (!mem_req_o) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_req_o) begin
      if (ack_wait == 2'd0) begin
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= read_word(mem_addr_o);
        mem_rng      = xorshift32(mem_rng);
        ack_wait    <= mem_rng[1:0];
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end
  end

  // decode stage model that is ready only while expected entries remain
  always @(posedge clk) begin
    logic [63:0] exp_entry;
    if (!rst_n) begin
      id_ready_i <= 1'b0;
    end else begin
      if (instr_valid_o && id_ready_i && !branch_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("instruction accepted at pc %h in %s with none expected", pc_o, cur_test);
        end else begin
          exp_entry = exp_q.pop_front();
          check_accept(exp_entry[63:32], exp_entry[31:0]);
        end
      end
      rdy_rng = xorshift32(rdy_rng);
      id_ready_i <= (exp_q.size() != 0) && ((rdy_rng % 100) < ready_pct);
    end
  end

  //////////////////////////////////////////////////
  // protocol and output checks
  //////////////////////////////////////////////////
  reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !mem_req_o && !instr_valid_o)
    else begin
      errors++;
      $display("mem_req_o or instr_valid_o high right after reset");
    end

  req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req_o) |-> !mem_ack_i)
    else begin
      errors++;
      $display("mem_req_o rose while mem_ack_i was high");
    end

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |-> (mem_addr_o[1:0] == 2'b00))
    else begin
      errors++;
      $display("mem_addr_o not word aligned under request");
    end

  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |=> !mem_req_o || $stable(mem_addr_o))
    else begin
      errors++;
      $display("mem_addr_o changed while mem_req_o was high");
    end

  req_drop: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && mem_ack_i |=> !mem_req_o)
    else begin
      errors++;
      $display("mem_req_o stayed high after ack was sampled");
    end

  // stalled outputs hold into the next cycle
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !id_ready_i && !branch_i |=>
      instr_valid_o && $stable(instr_o) && $stable(pc_o) && $stable(instr_compressed_o))
    else begin
      errors++;
      $display("outputs changed while stalled by id_ready_i");
    end

  compressed_zero: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && instr_compressed_o |-> (instr_o[31:16] == 16'h0000))
    else begin
      errors++;
      $display("compressed instruction with nonzero upper half");
    end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int word_tgt;
    int half_c_tgt;
    int half_32_tgt;
    build_program();
    word_tgt    = find_target(1200, 1'b0, 1'b1);
    half_c_tgt  = find_target(2000, 1'b1, 1'b0);
    half_32_tgt = find_target(2800, 1'b1, 1'b1);

    // first entry carries BOOT_ADDR so the first accept checks the reset pc
    cur_test  = "reset_stream";
    ready_pct = 100;
    queue_stream(BOOT_ADDR, N_RESET);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_drain();
    report_test();

    // long stall first so the FIFO fills up and the fetcher has to stop
    cur_test  = "backpressure";
    ready_pct = 0;
    queue_stream(stream_pc, N_BACKPRESSURE);
    repeat (N_STALL) @(negedge clk);
    ready_pct = 70;
    wait_drain();
    report_test();

    take_branch("branch_word", 32'(word_tgt * 2), N_BRANCH);
    take_branch("branch_half_c", 32'(half_c_tgt * 2), N_BRANCH);
    take_branch("branch_half_32", 32'(half_32_tgt * 2), N_BRANCH);

    $display("tests run: %0d, instructions checked: %0d, errors: %0d",
             tests_run, total_checked, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the expected instruction count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired in %s with %0d instructions still expected",
             cur_test, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- all.f
logic/fetch_pkg.sv
logic/word_fetcher.sv
logic/prefetch_fifo.sv
logic/instr_aligner.sv
logic/fetch_stage_top.sv
dv/tb_fetch_stage.sv

//--- Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
